// ==== src/rv32_branch_pkg.sv ====
`default_nettype none

package rv32_branch_pkg;

    // if_set and if_clear test bit 0 of the execute result
    typedef enum logic [1:0] {
        branch_never    = 2'b00,
        branch_always   = 2'b01,
        branch_if_set   = 2'b10,
        branch_if_clear = 2'b11
    } branch_op_t;

endpackage

`default_nettype wire

// ==== src/rv32_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_branch_unit import rv32_branch_pkg::*; (
    input  var branch_op_t  op,
    input  wire [31:0]      result,
    output logic            taken
);

    // execute leaves the comparison outcome in bit 0 of result
    always_comb begin
        case (op)
            branch_never: begin
                taken = 1'b0;
            end
            branch_always: begin
                taken = 1'b1;
            end
            branch_if_set: begin
                taken = result[0];
            end
            branch_if_clear: begin
                taken = ~result[0];
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv32_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_data_ram import rv32_mem_pkg::*; #(
    parameter int unsigned ADDR_BITS = 8
) (
    input  wire              clk,
    input  wire [31:0]       address,
    input  var byte_mask_t   write_mask,
    input  wire [31:0]       write_data,
    output logic [31:0]      read_data
);

    localparam int unsigned DEPTH = 2 ** ADDR_BITS;

    logic [31:0]          mem [DEPTH];
    logic [ADDR_BITS-1:0] index;

    // upper address bits are ignored so accesses past the end wrap
    assign index = address[ADDR_BITS+1:2];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (write_mask[lane]) begin
                mem[index][8*lane +: 8] <= write_data[8*lane +: 8];
            end
        end
    end

    // combinational read, so a load right after a store sees the new bytes
    assign read_data = mem[index];

endmodule

`default_nettype wire

// ==== src/rv32_mem_pkg.sv ====
`default_nettype none

package rv32_mem_pkg;

    // encodings match the execute stage, code 2'b11 is unused
    typedef enum logic [1:0] {
        mem_word = 2'b00,
        mem_half = 2'b01,
        mem_byte = 2'b10
    } mem_width_t;

    typedef struct packed {
        logic       read;
        logic       write;
        mem_width_t width;
        logic       zero_extend; // load fills upper bits with zeros instead of the sign
    } mem_ctrl_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] rd_value;
    } writeback_t;

    // bit 3 enables the lane at bits 31:24, bit 0 the lane at bits 7:0
    typedef logic [3:0] byte_mask_t;

endpackage

`default_nettype wire

// ==== src/rv32_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_stage import rv32_mem_pkg::*, rv32_branch_pkg::*; (
    input  wire              clk,
    input  wire              reset,

    input  wire              stall,
    input  wire              flush,

    input  var mem_ctrl_t    mem_ctrl,
    input  var branch_op_t   branch_op,
    input  wire [4:0]        rd,
    input  wire              rd_write,

    input  wire [31:0]       result,
    input  wire [31:0]       rs2_value,
    input  wire [31:0]       branch_pc,

    input  wire [31:0]       read_data,

    output logic [31:0]      address,
    output byte_mask_t       write_mask,
    output logic [31:0]      write_data,

    output logic             branch_taken,
    output logic [31:0]      branch_pc_next,

    output writeback_t       writeback
);

    logic [15:0] half_lane;
    logic [7:0]  byte_lane;
    logic [31:0] load_value;
    writeback_t  writeback_next;

    rv32_branch_unit branch_unit (
        .op     (branch_op),
        .result (result),
        .taken  (branch_taken)
    );

    assign branch_pc_next = branch_pc;
    assign address = result;

    // store data is replicated across every lane, the mask picks the real ones
    always_comb begin
        case (mem_ctrl.width)
            mem_half: begin
                write_data = {2{rs2_value[15:0]}};
                write_mask = result[0] ? 4'b0011 : 4'b1100; // only bit 0 picks the half
            end
            mem_byte: begin
                write_data = {4{rs2_value[7:0]}};
                case (result[1:0])
                    2'b00: write_mask = 4'b1000;
                    2'b01: write_mask = 4'b0100;
                    2'b10: write_mask = 4'b0010;
                    default: write_mask = 4'b0001;
                endcase
            end
            mem_word: begin
                write_data = rs2_value;
                write_mask = 4'b1111;
            end
            default: begin
                write_data = rs2_value;
                write_mask = 4'b0000; // unused width code never writes
            end
        endcase

        if (!mem_ctrl.write) begin
            write_mask = 4'b0000;
        end
    end

    // offset 0 sits in the most significant lane
    always_comb begin
        half_lane = result[0] ? read_data[15:0] : read_data[31:16];

        case (result[1:0])
            2'b00: byte_lane = read_data[31:24];
            2'b01: byte_lane = read_data[23:16];
            2'b10: byte_lane = read_data[15:8];
            default: byte_lane = read_data[7:0];
        endcase

        case (mem_ctrl.width)
            mem_half: begin
                load_value = {{16{~mem_ctrl.zero_extend & half_lane[15]}}, half_lane};
            end
            mem_byte: begin
                load_value = {{24{~mem_ctrl.zero_extend & byte_lane[7]}}, byte_lane};
            end
            default: begin
                load_value = read_data;
            end
        endcase
    end

    always_comb begin
        writeback_next.rd       = rd;
        writeback_next.rd_write = rd_write & ~flush; // a flushed instruction still moves along
        writeback_next.rd_value = mem_ctrl.read ? load_value : result;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            writeback <= '0;
        end else if (!stall) begin
            writeback <= writeback_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/rv32_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_subsystem import rv32_mem_pkg::*, rv32_branch_pkg::*; #(
    parameter int unsigned ADDR_BITS = 8
) (
    input  wire              clk,
    input  wire              reset,

    input  wire              stall,
    input  wire              flush,

    input  var mem_ctrl_t    mem_ctrl,
    input  var branch_op_t   branch_op,
    input  wire [4:0]        rd,
    input  wire              rd_write,

    input  wire [31:0]       result,
    input  wire [31:0]       rs2_value,
    input  wire [31:0]       branch_pc,

    output writeback_t       writeback,
    output logic             branch_taken,
    output logic [31:0]      branch_pc_next
);

    logic [31:0] address;
    byte_mask_t  write_mask;
    logic [31:0] write_data;
    logic [31:0] read_data;

    rv32_mem_stage mem_stage (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .mem_ctrl       (mem_ctrl),
        .branch_op      (branch_op),
        .rd             (rd),
        .rd_write       (rd_write),
        .result         (result),
        .rs2_value      (rs2_value),
        .branch_pc      (branch_pc),
        .read_data      (read_data),
        .address        (address),
        .write_mask     (write_mask),
        .write_data     (write_data),
        .branch_taken   (branch_taken),
        .branch_pc_next (branch_pc_next),
        .writeback      (writeback)
    );

    rv32_data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) data_ram (
        .clk        (clk),
        .address    (address),
        .write_mask (write_mask),
        .write_data (write_data),
        .read_data  (read_data)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
src/rv32_mem_pkg.sv
src/rv32_branch_pkg.sv
src/rv32_branch_unit.sv
src/rv32_mem_stage.sv
src/rv32_data_ram.sv
src/rv32_mem_subsystem.sv
verification/rv32_mem_tb.sv

// ==== verification/mem_cases.txt ====
# st fl read write width(0 word,1 half,2 byte) zext bop(0 never,1 always,2 set,3 clear) rd rd_write
# result rs2_value branch_pc, then expected branch_taken rd_write rd_value, all hex
# word store then word load
0 0 0 1 0 0 0 01 0 00000040 a5b6c7d8 00000100 0 0 00000040
0 0 1 0 0 0 1 05 1 00000040 00000000 00000104 1 1 a5b6c7d8
# byte and halfword stores into one word
0 0 0 1 0 0 0 00 0 00000044 11223344 00000108 0 0 00000044
0 0 0 1 2 0 0 00 0 00000045 000000ee 0000010c 0 0 00000045
0 0 1 0 0 0 0 06 1 00000044 00000000 00000110 0 1 11ee3344
0 0 0 1 1 0 0 00 0 00000046 0000beef 00000114 0 0 00000046
0 0 1 0 0 0 0 07 1 00000044 00000000 00000118 0 1 beef3344
0 0 0 1 1 0 0 00 0 00000045 00001357 0000011c 0 0 00000045
0 0 1 0 0 0 0 07 1 00000044 00000000 00000120 0 1 beef1357
0 0 0 1 2 0 0 00 0 00000047 0000007c 00000124 0 0 00000047
0 0 0 1 2 0 0 00 0 00000044 00000001 00000128 0 0 00000044
0 0 0 1 2 0 0 00 0 00000046 ffffff9a 0000012c 0 0 00000046
0 0 1 0 0 0 0 08 1 00000044 00000000 00000130 0 1 01ef9a7c
# sign and zero extension of byte and halfword loads
0 0 1 0 2 0 0 09 1 00000044 00000000 00000134 0 1 00000001
0 0 1 0 2 0 0 09 1 00000045 00000000 00000138 0 1 ffffffef
0 0 1 0 2 1 0 09 1 00000045 00000000 0000013c 0 1 000000ef
0 0 1 0 2 0 0 09 1 00000046 00000000 00000140 0 1 ffffff9a
0 0 1 0 2 1 0 09 1 00000046 00000000 00000144 0 1 0000009a
0 0 1 0 2 0 0 09 1 00000047 00000000 00000148 0 1 0000007c
0 0 1 0 1 0 0 0b 1 00000044 00000000 0000014c 0 1 000001ef
0 0 1 0 1 0 0 0b 1 00000045 00000000 00000150 0 1 ffff9a7c
0 0 1 0 1 1 0 0b 1 00000045 00000000 00000154 0 1 00009a7c
0 0 1 0 1 0 0 0b 1 00000047 00000000 00000158 0 1 ffff9a7c
0 0 0 1 0 0 0 00 0 00000048 80017fff 0000015c 0 0 00000048
0 0 1 0 1 0 0 0b 1 00000048 00000000 00000160 0 1 ffff8001
0 0 1 0 1 1 0 0b 1 00000048 00000000 00000164 0 1 00008001
0 0 1 0 1 0 0 0b 1 00000049 00000000 00000168 0 1 00007fff
0 0 1 0 2 0 0 0b 1 00000048 00000000 0000016c 0 1 ffffff80
# addresses past the RAM wrap around
0 0 0 1 0 0 0 00 0 00000410 cafef00d 00000170 0 0 00000410
0 0 1 0 0 0 0 0c 1 00000010 00000000 00000174 0 1 cafef00d
# branch decisions on non-load cases
0 0 0 0 0 0 0 0a 1 00000001 00000000 00002000 0 1 00000001
0 0 0 0 0 0 1 0a 1 00000000 00000000 00002004 1 1 00000000
0 0 0 0 0 0 2 0a 1 12345679 00000000 00002008 1 1 12345679
0 0 0 0 0 0 2 0a 1 12345678 00000000 0000200c 0 1 12345678
0 0 0 0 0 0 3 0a 1 87654320 00000000 00002010 1 1 87654320
0 0 0 0 0 0 3 0a 1 87654321 00000000 00002014 0 1 87654321
0 0 0 0 0 0 1 0a 1 00000003 00000000 00002018 1 1 00000003
0 0 0 0 0 0 0 0c 1 0000abcd 00000000 0000201c 0 1 0000abcd
# flush and stall
0 1 0 0 0 0 0 0d 1 00001111 00000000 00003000 0 0 00001111
1 0 0 0 0 0 2 0e 1 00002222 00000000 00003004 0 0 00001111
1 1 0 0 0 0 2 0f 1 00003333 00000000 00003008 1 0 00001111
0 0 0 0 0 0 0 10 1 00004444 00000000 0000300c 0 1 00004444
1 1 0 0 0 0 3 11 1 00005555 00000000 00003010 0 1 00004444
1 0 0 1 0 0 1 12 1 00000050 0badcafe 00003014 1 1 00004444
0 0 1 0 0 0 0 12 1 00000050 00000000 00003018 0 1 0badcafe
0 1 1 0 0 0 0 13 1 00000040 00000000 0000301c 0 0 a5b6c7d8
0 0 0 0 0 0 3 14 1 deadbeef 00000000 00003020 0 1 deadbeef

// ==== verification/rv32_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_mem_tb import rv32_mem_pkg::*, rv32_branch_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int ADDR_BITS = 8;
    localparam int RAM_WORDS = 2 ** ADDR_BITS;
    localparam string CASE_FILE = "verification/mem_cases.txt";

    typedef struct packed {
        logic        stall;
        logic        flush;
        mem_ctrl_t   ctrl;
        branch_op_t  branch_op;
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] result;
        logic [31:0] rs2_value;
        logic [31:0] branch_pc;
        logic        exp_taken;
        logic        exp_rd_write;
        logic [31:0] exp_rd_value;
    } access_case_t;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    mem_ctrl_t   mem_ctrl;
    branch_op_t  branch_op;
    logic [4:0]  rd;
    logic        rd_write;
    logic [31:0] result;
    logic [31:0] rs2_value;
    logic [31:0] branch_pc;
    writeback_t  writeback;
    logic        branch_taken;
    logic [31:0] branch_pc_next;

    access_case_t cases[$];
    bit           cases_loaded = 1'b0;
    int           current_case = 0;
    logic [4:0]   expected_rd = 5'd0; // rd only moves when the stage is not stalled

    rv32_mem_subsystem #(
        .ADDR_BITS (ADDR_BITS)
    ) DUT (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .mem_ctrl       (mem_ctrl),
        .branch_op      (branch_op),
        .rd             (rd),
        .rd_write       (rd_write),
        .result         (result),
        .rs2_value      (rs2_value),
        .branch_pc      (branch_pc),
        .writeback      (writeback),
        .branch_taken   (branch_taken),
        .branch_pc_next (branch_pc_next)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: case %0d, %s is %h, expected %h",
                     $time, current_case, field, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic drive_idle();
        stall     = 1'b0;
        flush     = 1'b0;
        mem_ctrl  = '0;
        branch_op = branch_never;
        rd        = 5'd0;
        rd_write  = 1'b0;
        result    = 32'd0;
        rs2_value = 32'd0;
        branch_pc = 32'd0;
    endtask

    task automatic load_cases();
        int           fd;
        int           fields;
        string        line;
        logic [31:0]  st, fl, rdc, wrc, wd, ze, bop;
        logic [31:0]  rdn, rdw, res, rs2, bpc;
        logic [31:0]  tk, erw, erv;
        access_case_t c;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the case file %s", CASE_FILE);
            $display("TEST FAIL");
            $fatal(1, "case file missing");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 st, fl, rdc, wrc, wd, ze, bop, rdn, rdw, res, rs2, bpc,
                                 tk, erw, erv);
                if (fields == 15) begin
                    c.stall            = st[0];
                    c.flush            = fl[0];
                    c.ctrl.read        = rdc[0];
                    c.ctrl.write       = wrc[0];
                    c.ctrl.width       = mem_width_t'(wd[1:0]);
                    c.ctrl.zero_extend = ze[0];
                    c.branch_op        = branch_op_t'(bop[1:0]);
                    c.rd               = rdn[4:0];
                    c.rd_write         = rdw[0];
                    c.result           = res;
                    c.rs2_value        = rs2;
                    c.branch_pc        = bpc;
                    c.exp_taken        = tk[0];
                    c.exp_rd_write     = erw[0];
                    c.exp_rd_value     = erv;
                    cases.push_back(c);
                end else if (fields > 0) begin
                    $display("case file line has %0d columns instead of 15: %s", fields, line);
                    $display("TEST FAIL");
                    $fatal(1, "malformed case file");
                end
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            $display("the case file %s holds no cases", CASE_FILE);
            $display("TEST FAIL");
            $fatal(1, "empty case file");
        end
    endtask

    task automatic apply_case(input access_case_t c);
        stall     = c.stall;
        flush     = c.flush;
        mem_ctrl  = c.ctrl;
        branch_op = c.branch_op;
        rd        = c.rd;
        rd_write  = c.rd_write;
        result    = c.result;
        rs2_value = c.rs2_value;
        branch_pc = c.branch_pc;
    endtask

    task automatic check_writeback(input access_case_t c);
        if (!c.stall) begin
            expected_rd = c.rd;
        end
        check_value("writeback.rd", writeback.rd, expected_rd);
        check_value("writeback.rd_write", writeback.rd_write, c.exp_rd_write);
        check_value("writeback.rd_value", writeback.rd_value, c.exp_rd_value);
    endtask

    // every word gets a random value so later loads never see unknowns
    task automatic fill_memory();
        for (int w = 0; w < RAM_WORDS; w++) begin
            @(posedge clk);
            #1;
            mem_ctrl.read        = 1'b0;
            mem_ctrl.write       = 1'b1;
            mem_ctrl.width       = mem_word;
            mem_ctrl.zero_extend = 1'b0;
            result               = w * 4;
            rs2_value            = $urandom();
        end
    endtask

    initial begin
        void'($urandom(15));
        drive_idle();
        reset = 1'b1;
        load_cases();
        cases_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("writeback.rd_write after reset", writeback.rd_write, 1'b0);
        check_value("writeback.rd after reset", writeback.rd, 5'd0);
        check_value("writeback.rd_value after reset", writeback.rd_value, 32'd0);
        fill_memory();
        for (int i = 0; i < cases.size(); i++) begin
            @(posedge clk);
            #0.5;
            if (i > 0) begin
                check_writeback(cases[i - 1]); // result of the previous case, just before the drive
            end
            #0.5;
            current_case = i + 1;
            apply_case(cases[i]);
            #2;
            check_value("branch_taken", branch_taken, cases[i].exp_taken);
            check_value("branch_pc_next", branch_pc_next, cases[i].branch_pc);
        end
        @(posedge clk);
        #0.5;
        check_writeback(cases[cases.size() - 1]);
        $display("%0d cases checked", cases.size());
        $display("TEST PASS");
        $finish;
    end

    // each access, fill stores included, gets four clock periods of margin
    initial begin
        longint limit_ns;
        wait (cases_loaded);
        limit_ns = (cases.size() + RAM_WORDS) * 4 * CLK_PERIOD + 200;
        #(limit_ns);
        $display("the run did not finish within %0d ns and is considered hung", limit_ns);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
